// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_decode_stage
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass if $(LOG) holds RESULT: PASS"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+src
+incdir+verif
src/rv_decode_pkg.sv
src/decode_fields_if.sv
src/instr_field_extract.sv
src/control_unit.sv
src/decode_output_reg.sv
src/decode_stage.sv
verif/tb_decode_stage.sv

// ==== src/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

module control_unit (
	input  logic                      write_done,
	decode_fields_if.consumer         fields,
	output logic                      jump,
	output logic                      branch,
	output rv_decode_pkg::alu_src_a_t alu_src_a_select,
	output rv_decode_pkg::alu_src_b_t alu_src_b_select,
	output logic                      csr_write_enable,
	output logic                      register_file_write,
	output rv_decode_pkg::rf_wd_sel_t register_file_write_data_select,
	output logic                      memory_read,
	output logic                      memory_write,
	output logic                      pc_stall,
	output logic                      illegal
);

	// Hold the PC until the previous write completes
	assign pc_stall = !write_done;

	always_comb begin
		// Inactive word, each opcode only sets what it needs
		jump                            = 1'b0;
		branch                          = 1'b0;
		alu_src_a_select                = `ALU_SRC_A_NONE;
		alu_src_b_select                = `ALU_SRC_B_NONE;
		csr_write_enable                = 1'b0;
		register_file_write             = 1'b0;
		register_file_write_data_select = `RF_WD_NONE;
		memory_read                     = 1'b0;
		memory_write                    = 1'b0;
		illegal                         = 1'b0;

		case (fields.opcode)
			`OPCODE_LUI: begin
				// Immediate goes straight to rd, no ALU
				register_file_write             = 1'b1;
				register_file_write_data_select = `RF_WD_LUI;
			end
			`OPCODE_AUIPC: begin
				// PC + upper immediate
				alu_src_a_select                = `ALU_SRC_A_PC;
				alu_src_b_select                = `ALU_SRC_B_IMM;
				register_file_write             = 1'b1;
				register_file_write_data_select = `RF_WD_ALU;
			end
			`OPCODE_JAL: begin
				// Target PC + imm, link PC+4
				jump                            = 1'b1;
				alu_src_a_select                = `ALU_SRC_A_PC;
				alu_src_b_select                = `ALU_SRC_B_IMM;
				register_file_write             = 1'b1;
				register_file_write_data_select = `RF_WD_JUMP;
			end
			`OPCODE_JALR: begin
				// Target R[rs1] + imm, link PC+4
				jump                            = 1'b1;
				alu_src_a_select                = `ALU_SRC_A_RD1;
				alu_src_b_select                = `ALU_SRC_B_IMM;
				register_file_write             = 1'b1;
				register_file_write_data_select = `RF_WD_JUMP;
			end
			`OPCODE_BRANCH: begin
				// Compare R[rs1] with R[rs2], no write-back
				branch           = 1'b1;
				alu_src_a_select = `ALU_SRC_A_RD1;
				alu_src_b_select = `ALU_SRC_B_RD2;
			end
			`OPCODE_LOAD: begin
				// Address R[rs1] + imm
				alu_src_a_select                = `ALU_SRC_A_RD1;
				alu_src_b_select                = `ALU_SRC_B_IMM;
				register_file_write             = 1'b1;
				register_file_write_data_select = `RF_WD_LOAD;
				memory_read                     = 1'b1;
			end
			`OPCODE_STORE: begin
				// Address R[rs1] + imm
				alu_src_a_select = `ALU_SRC_A_RD1;
				alu_src_b_select = `ALU_SRC_B_IMM;
				memory_write     = 1'b1;
			end
			`OPCODE_ITYPE: begin
				alu_src_a_select = `ALU_SRC_A_RD1;
				// Right shifts take shamt instead of the full immediate
				alu_src_b_select = (fields.funct3 == `ITYPE_SRXI) ?
					`ALU_SRC_B_SHAMT : `ALU_SRC_B_IMM;
				register_file_write             = 1'b1;
				register_file_write_data_select = `RF_WD_ALU;
			end
			`OPCODE_RTYPE: begin
				alu_src_a_select                = `ALU_SRC_A_RD1;
				alu_src_b_select                = `ALU_SRC_B_RD2;
				register_file_write             = 1'b1;
				register_file_write_data_select = `RF_WD_ALU;
			end
			`OPCODE_FENCE: begin
				// Nothing to do in order, single-issue core
			end
			`OPCODE_ENVIRONMENT: begin
				// funct3 zero is ECALL/EBREAK, treated as no-op
				if (fields.funct3 != 3'b000) begin
					csr_write_enable                = 1'b1;
					register_file_write             = 1'b1;
					register_file_write_data_select = `RF_WD_CSR;
					// Plain writes need no old CSR value on B
					if (fields.funct3 == `CSR_CSRRW || fields.funct3 == `CSR_CSRRWI)
						alu_src_b_select = `ALU_SRC_B_NONE;
					else
						alu_src_b_select = `ALU_SRC_B_CSR;
					// Register forms read R[rs1], immediate forms use uimm
					if (fields.funct3 == `CSR_CSRRW || fields.funct3 == `CSR_CSRRS ||
						fields.funct3 == `CSR_CSRRC)
						alu_src_a_select = `ALU_SRC_A_RD1;
					else
						alu_src_a_select = `ALU_SRC_A_RS1;
				end
			end
			default: begin
				// Unknown opcode, word stays inactive
				illegal = 1'b1;
			end
		endcase
	end

	// At most one of PC redirect, branch or memory access per instruction
	always_comb begin
		assert ($onehot0({jump, branch, memory_read, memory_write}))
			else $error("control_unit: jump/branch/load/store overlap");
		assert (!csr_write_enable || register_file_write)
			else $error("control_unit: CSR write without rd write-back");
	end

endmodule

`default_nettype wire

// ==== src/decode_fields_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface decode_fields_if;
	import rv_decode_pkg::*;

	// Combinational fields of the current instruction
	opcode_t   opcode;
	funct3_t   funct3;
	reg_addr_t rd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	csr_addr_t csr_addr;
	imm_t      imm;

	// Field extractor side
	modport producer (
		output opcode, funct3, rd, rs1, rs2, csr_addr, imm
	);

	// Control unit only looks at the decode keys
	modport consumer (
		input opcode, funct3
	);

	// Output register captures everything
	modport sink (
		input opcode, funct3, rd, rs1, rs2, csr_addr, imm
	);

endinterface

`default_nettype wire

// ==== src/decode_output_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

module decode_output_reg (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      instr_valid,
	decode_fields_if.sink             fields,
	input  logic                      dec_jump,
	input  logic                      dec_branch,
	input  rv_decode_pkg::alu_src_a_t dec_alu_src_a_select,
	input  rv_decode_pkg::alu_src_b_t dec_alu_src_b_select,
	input  logic                      dec_csr_write_enable,
	input  logic                      dec_register_file_write,
	input  rv_decode_pkg::rf_wd_sel_t dec_register_file_write_data_select,
	input  logic                      dec_memory_read,
	input  logic                      dec_memory_write,
	input  logic                      dec_illegal,
	output logic                      out_valid,
	output rv_decode_pkg::reg_addr_t  rd_addr,
	output rv_decode_pkg::reg_addr_t  rs1_addr,
	output rv_decode_pkg::reg_addr_t  rs2_addr,
	output rv_decode_pkg::csr_addr_t  csr_addr,
	output rv_decode_pkg::imm_t       imm,
	output logic                      jump,
	output logic                      branch,
	output rv_decode_pkg::alu_src_a_t alu_src_a_select,
	output rv_decode_pkg::alu_src_b_t alu_src_b_select,
	output logic                      csr_write_enable,
	output logic                      register_file_write,
	output rv_decode_pkg::rf_wd_sel_t register_file_write_data_select,
	output logic                      memory_read,
	output logic                      memory_write,
	output logic                      illegal
);

	// Strobe and control word reset to inactive
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid                       <= 1'b0;
			jump                            <= 1'b0;
			branch                          <= 1'b0;
			alu_src_a_select                <= `ALU_SRC_A_NONE;
			alu_src_b_select                <= `ALU_SRC_B_NONE;
			csr_write_enable                <= 1'b0;
			register_file_write             <= 1'b0;
			register_file_write_data_select <= `RF_WD_NONE;
			memory_read                     <= 1'b0;
			memory_write                    <= 1'b0;
			illegal                         <= 1'b0;
		end else begin
			// One pulse per accepted instruction
			out_valid <= instr_valid;
			if (instr_valid) begin
				jump                            <= dec_jump;
				branch                          <= dec_branch;
				alu_src_a_select                <= dec_alu_src_a_select;
				alu_src_b_select                <= dec_alu_src_b_select;
				csr_write_enable                <= dec_csr_write_enable;
				register_file_write             <= dec_register_file_write;
				register_file_write_data_select <= dec_register_file_write_data_select;
				memory_read                     <= dec_memory_read;
				memory_write                    <= dec_memory_write;
				illegal                         <= dec_illegal;
			end
		end
	end

	// Operand fields qualified by out_valid downstream
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			rd_addr  <= fields.rd;
			rs1_addr <= fields.rs1;
			rs2_addr <= fields.rs2;
			csr_addr <= fields.csr_addr;
			imm      <= fields.imm;
		end
	end

	// No output strobe without a strobe one cycle earlier
	assert property (@(posedge clk) disable iff (!arst_n)
		!instr_valid |=> !out_valid)
		else $error("decode_output_reg: out_valid without instr_valid");

	// Strobe must be clean once out of reset
	assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(out_valid))
		else $error("decode_output_reg: out_valid is X");

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      instr_valid,
	input  rv_decode_pkg::instr_t     instr,
	input  logic                      write_done,
	output logic                      out_valid,
	output rv_decode_pkg::reg_addr_t  rd_addr,
	output rv_decode_pkg::reg_addr_t  rs1_addr,
	output rv_decode_pkg::reg_addr_t  rs2_addr,
	output rv_decode_pkg::csr_addr_t  csr_addr,
	output rv_decode_pkg::imm_t       imm,
	output logic                      jump,
	output logic                      branch,
	output rv_decode_pkg::alu_src_a_t alu_src_a_select,
	output rv_decode_pkg::alu_src_b_t alu_src_b_select,
	output logic                      csr_write_enable,
	output logic                      register_file_write,
	output rv_decode_pkg::rf_wd_sel_t register_file_write_data_select,
	output logic                      memory_read,
	output logic                      memory_write,
	output logic                      illegal,
	output logic                      pc_stall
);
	import rv_decode_pkg::*;

	// Unregistered control word
	logic       dec_jump;
	logic       dec_branch;
	alu_src_a_t dec_alu_src_a_select;
	alu_src_b_t dec_alu_src_b_select;
	logic       dec_csr_write_enable;
	logic       dec_register_file_write;
	rf_wd_sel_t dec_register_file_write_data_select;
	logic       dec_memory_read;
	logic       dec_memory_write;
	logic       dec_illegal;

	decode_fields_if u_fields ();

	// Slice fields and build immediate
	instr_field_extract u_instr_field_extract (
		.instr  (instr),
		.fields (u_fields)
	);

	// pc_stall leaves here unregistered
	control_unit u_control_unit (
		.write_done                      (write_done),
		.fields                          (u_fields),
		.jump                            (dec_jump),
		.branch                          (dec_branch),
		.alu_src_a_select                (dec_alu_src_a_select),
		.alu_src_b_select                (dec_alu_src_b_select),
		.csr_write_enable                (dec_csr_write_enable),
		.register_file_write             (dec_register_file_write),
		.register_file_write_data_select (dec_register_file_write_data_select),
		.memory_read                     (dec_memory_read),
		.memory_write                    (dec_memory_write),
		.pc_stall                        (pc_stall),
		.illegal                         (dec_illegal)
	);

	// One-cycle pipeline register toward execute
	decode_output_reg u_decode_output_reg (
		.clk                                 (clk),
		.arst_n                              (arst_n),
		.instr_valid                         (instr_valid),
		.fields                              (u_fields),
		.dec_jump                            (dec_jump),
		.dec_branch                          (dec_branch),
		.dec_alu_src_a_select                (dec_alu_src_a_select),
		.dec_alu_src_b_select                (dec_alu_src_b_select),
		.dec_csr_write_enable                (dec_csr_write_enable),
		.dec_register_file_write             (dec_register_file_write),
		.dec_register_file_write_data_select (dec_register_file_write_data_select),
		.dec_memory_read                     (dec_memory_read),
		.dec_memory_write                    (dec_memory_write),
		.dec_illegal                         (dec_illegal),
		.out_valid                           (out_valid),
		.rd_addr                             (rd_addr),
		.rs1_addr                            (rs1_addr),
		.rs2_addr                            (rs2_addr),
		.csr_addr                            (csr_addr),
		.imm                                 (imm),
		.jump                                (jump),
		.branch                              (branch),
		.alu_src_a_select                    (alu_src_a_select),
		.alu_src_b_select                    (alu_src_b_select),
		.csr_write_enable                    (csr_write_enable),
		.register_file_write                 (register_file_write),
		.register_file_write_data_select     (register_file_write_data_select),
		.memory_read                         (memory_read),
		.memory_write                        (memory_write),
		.illegal                             (illegal)
	);

endmodule

`default_nettype wire

// ==== src/instr_field_extract.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

module instr_field_extract (
	input  rv_decode_pkg::instr_t instr,
	decode_fields_if.producer     fields
);
	import rv_decode_pkg::*;

	imm_t imm;

	// Fixed bit positions, same for every format
	assign fields.opcode   = instr[6:0];
	assign fields.funct3   = instr[14:12];
	assign fields.rd       = instr[11:7];
	assign fields.rs1      = instr[19:15];
	assign fields.rs2      = instr[24:20];
	assign fields.csr_addr = instr[31:20];

	// Immediate by format, instr[31] is always the sign bit
	always_comb begin
		imm = '0;
		case (instr[6:0])
			`OPCODE_JALR, `OPCODE_LOAD, `OPCODE_ITYPE: begin
				// I-type
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			`OPCODE_STORE: begin
				// S-type, split around rd slot
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			`OPCODE_BRANCH: begin
				// B-type, halfword aligned
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			`OPCODE_LUI, `OPCODE_AUIPC: begin
				// U-type, upper 20 bits
				imm = {instr[31:12], 12'b0};
			end
			`OPCODE_JAL: begin
				// J-type, halfword aligned
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			`OPCODE_ENVIRONMENT: begin
				// CSR uimm lives in the rs1 slot, zero-extended
				imm = {27'b0, instr[19:15]};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

	assign fields.imm = imm;

endmodule

`default_nettype wire

// ==== src/rv_decode_config.svh ====
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// RV32I base opcodes, instr[6:0]
`define OPCODE_LUI         7'b0110111
`define OPCODE_AUIPC       7'b0010111
`define OPCODE_JAL         7'b1101111
`define OPCODE_JALR        7'b1100111
`define OPCODE_BRANCH      7'b1100011
`define OPCODE_LOAD        7'b0000011
`define OPCODE_STORE       7'b0100011
`define OPCODE_ITYPE       7'b0010011
`define OPCODE_RTYPE       7'b0110011
`define OPCODE_FENCE       7'b0001111
`define OPCODE_ENVIRONMENT 7'b1110011

// Shift right (SRLI and SRAI share funct3)
`define ITYPE_SRXI 3'b101

// Zicsr funct3 codes
`define CSR_CSRRW  3'b001
`define CSR_CSRRS  3'b010
`define CSR_CSRRC  3'b011
`define CSR_CSRRWI 3'b101
`define CSR_CSRRSI 3'b110
`define CSR_CSRRCI 3'b111

// ALU operand A select
`define ALU_SRC_A_NONE 2'b00
`define ALU_SRC_A_PC   2'b01
`define ALU_SRC_A_RD1  2'b10
`define ALU_SRC_A_RS1  2'b11

// ALU operand B select
`define ALU_SRC_B_NONE  3'b000
`define ALU_SRC_B_IMM   3'b001
`define ALU_SRC_B_RD2   3'b010
`define ALU_SRC_B_SHAMT 3'b011
`define ALU_SRC_B_CSR   3'b100

// Register file write-data select
`define RF_WD_NONE 3'b000
`define RF_WD_LUI  3'b001
`define RF_WD_ALU  3'b010
`define RF_WD_JUMP 3'b011
`define RF_WD_LOAD 3'b100
`define RF_WD_CSR  3'b101

`endif

// ==== src/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

	// Raw 32-bit instruction word
	typedef logic [31:0] instr_t;

	// instr[6:0]
	typedef logic [6:0] opcode_t;

	// instr[14:12]
	typedef logic [2:0] funct3_t;

	// rd, rs1 or rs2 index
	typedef logic [4:0] reg_addr_t;

	// Sign-extended immediate, or zero-extended CSR uimm
	typedef logic [31:0] imm_t;

	// instr[31:20] for Zicsr
	typedef logic [11:0] csr_addr_t;

	// Operand A select, values from ALU_SRC_A_* macros
	typedef logic [1:0] alu_src_a_t;

	// Operand B select, values from ALU_SRC_B_* macros
	typedef logic [2:0] alu_src_b_t;

	// Write-back source, values from RF_WD_* macros
	typedef logic [2:0] rf_wd_sel_t;

endpackage

`default_nettype wire

// ==== verif/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

`include "rv_decode_config.svh"

// Control word in DUT output order
typedef struct packed {
	logic       jump;
	logic       branch;
	alu_src_a_t alu_src_a;
	alu_src_b_t alu_src_b;
	logic       csr_we;
	logic       rf_write;
	rf_wd_sel_t rf_wd_sel;
	logic       mem_read;
	logic       mem_write;
	logic       illegal;
} ctrl_word_t;

// Everything expected for one instruction
typedef struct packed {
	ctrl_word_t ctrl;
	imm_t       imm;
	reg_addr_t  rd;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	csr_addr_t  csr_addr;
} decode_exp_t;

// Inactive word, selects at NONE
function automatic ctrl_word_t idle_ctrl();
	ctrl_word_t c;
	c.jump      = 1'b0;
	c.branch    = 1'b0;
	c.alu_src_a = `ALU_SRC_A_NONE;
	c.alu_src_b = `ALU_SRC_B_NONE;
	c.csr_we    = 1'b0;
	c.rf_write  = 1'b0;
	c.rf_wd_sel = `RF_WD_NONE;
	c.mem_read  = 1'b0;
	c.mem_write = 1'b0;
	c.illegal   = 1'b0;
	return c;
endfunction

function automatic logic is_listed_opcode(input opcode_t op);
	case (op)
		`OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL, `OPCODE_JALR, `OPCODE_BRANCH,
		`OPCODE_LOAD, `OPCODE_STORE, `OPCODE_ITYPE, `OPCODE_RTYPE, `OPCODE_FENCE,
		`OPCODE_ENVIRONMENT: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// Expected decode of one instruction, straight from the ISA formats
function automatic decode_exp_t decode_ref(input instr_t i);
	decode_exp_t e;
	funct3_t     f3;
	f3         = i[14:12];
	e.ctrl     = idle_ctrl();
	e.imm      = '0;
	e.rd       = i[11:7];
	e.rs1      = i[19:15];
	e.rs2      = i[24:20];
	e.csr_addr = i[31:20];
	case (i[6:0])
		`OPCODE_LUI: begin
			e.imm            = {i[31:12], 12'h000};
			e.ctrl.rf_write  = 1'b1;
			e.ctrl.rf_wd_sel = `RF_WD_LUI;
		end
		`OPCODE_AUIPC: begin
			e.imm            = {i[31:12], 12'h000};
			e.ctrl.alu_src_a = `ALU_SRC_A_PC;
			e.ctrl.alu_src_b = `ALU_SRC_B_IMM;
			e.ctrl.rf_write  = 1'b1;
			e.ctrl.rf_wd_sel = `RF_WD_ALU;
		end
		`OPCODE_JAL: begin
			// J offset, bit 0 always clear
			e.imm            = imm_t'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
			e.ctrl.jump      = 1'b1;
			e.ctrl.alu_src_a = `ALU_SRC_A_PC;
			e.ctrl.alu_src_b = `ALU_SRC_B_IMM;
			e.ctrl.rf_write  = 1'b1;
			e.ctrl.rf_wd_sel = `RF_WD_JUMP;
		end
		`OPCODE_JALR: begin
			e.imm            = imm_t'($signed(i[31:20]));
			e.ctrl.jump      = 1'b1;
			e.ctrl.alu_src_a = `ALU_SRC_A_RD1;
			e.ctrl.alu_src_b = `ALU_SRC_B_IMM;
			e.ctrl.rf_write  = 1'b1;
			e.ctrl.rf_wd_sel = `RF_WD_JUMP;
		end
		`OPCODE_BRANCH: begin
			e.imm            = imm_t'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
			e.ctrl.branch    = 1'b1;
			e.ctrl.alu_src_a = `ALU_SRC_A_RD1;
			e.ctrl.alu_src_b = `ALU_SRC_B_RD2;
		end
		`OPCODE_LOAD: begin
			e.imm            = imm_t'($signed(i[31:20]));
			e.ctrl.alu_src_a = `ALU_SRC_A_RD1;
			e.ctrl.alu_src_b = `ALU_SRC_B_IMM;
			e.ctrl.rf_write  = 1'b1;
			e.ctrl.rf_wd_sel = `RF_WD_LOAD;
			e.ctrl.mem_read  = 1'b1;
		end
		`OPCODE_STORE: begin
			e.imm            = imm_t'($signed({i[31:25], i[11:7]}));
			e.ctrl.alu_src_a = `ALU_SRC_A_RD1;
			e.ctrl.alu_src_b = `ALU_SRC_B_IMM;
			e.ctrl.mem_write = 1'b1;
		end
		`OPCODE_ITYPE: begin
			e.imm            = imm_t'($signed(i[31:20]));
			e.ctrl.alu_src_a = `ALU_SRC_A_RD1;
			e.ctrl.alu_src_b = (f3 == `ITYPE_SRXI) ? `ALU_SRC_B_SHAMT : `ALU_SRC_B_IMM;
			e.ctrl.rf_write  = 1'b1;
			e.ctrl.rf_wd_sel = `RF_WD_ALU;
		end
		`OPCODE_RTYPE: begin
			e.ctrl.alu_src_a = `ALU_SRC_A_RD1;
			e.ctrl.alu_src_b = `ALU_SRC_B_RD2;
			e.ctrl.rf_write  = 1'b1;
			e.ctrl.rf_wd_sel = `RF_WD_ALU;
		end
		`OPCODE_FENCE: begin
			e.imm = '0;
		end
		`OPCODE_ENVIRONMENT: begin
			// uimm in the rs1 slot
			e.imm = {27'b0, i[19:15]};
			if (f3 != 3'b000) begin
				e.ctrl.csr_we    = 1'b1;
				e.ctrl.rf_write  = 1'b1;
				e.ctrl.rf_wd_sel = `RF_WD_CSR;
				// funct3[2] marks the uimm forms, low bits 01 the plain writes
				e.ctrl.alu_src_a = f3[2] ? `ALU_SRC_A_RS1 : `ALU_SRC_A_RD1;
				e.ctrl.alu_src_b = (f3[1:0] == 2'b01) ? `ALU_SRC_B_NONE : `ALU_SRC_B_CSR;
			end
		end
		default: begin
			e.ctrl.illegal = 1'b1;
		end
	endcase
	return e;
endfunction

`endif

// ==== verif/tb_decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_decode_stage;
	import rv_decode_pkg::*;

	`include "decode_model.svh"

	localparam int DRAIN_LIMIT = 50;

	logic       clk;
	logic       arst_n;
	logic       instr_valid;
	instr_t     instr;
	logic       write_done;
	logic       out_valid;
	reg_addr_t  rd_addr;
	reg_addr_t  rs1_addr;
	reg_addr_t  rs2_addr;
	csr_addr_t  csr_addr;
	imm_t       imm;
	logic       jump;
	logic       branch;
	alu_src_a_t alu_src_a_select;
	alu_src_b_t alu_src_b_select;
	logic       csr_write_enable;
	logic       register_file_write;
	rf_wd_sel_t register_file_write_data_select;
	logic       memory_read;
	logic       memory_write;
	logic       illegal;
	logic       pc_stall;

	integer seed = 14;
	int     cycle = 0;
	int     mismatch_count = 0;
	int     protocol_count = 0;
	int     timeout_count = 0;

	// Outstanding strobes in send order
	instr_t instr_q[$];
	string  name_q[$];
	int     cycle_q[$];

	// Compare process scratch
	instr_t      sent_instr;
	string       sent_name;
	int          sent_cycle;
	decode_exp_t exp_word;

	// Stimulus scratch
	int      k;
	int      n;
	int      wait_cycles;
	instr_t  rnd;
	opcode_t op;

	opcode_t listed_ops [11] = '{`OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL, `OPCODE_JALR,
		`OPCODE_BRANCH, `OPCODE_LOAD, `OPCODE_STORE, `OPCODE_ITYPE, `OPCODE_RTYPE,
		`OPCODE_FENCE, `OPCODE_ENVIRONMENT};
	// Formats with an immediate
	opcode_t imm_ops [8] = '{`OPCODE_JALR, `OPCODE_LOAD, `OPCODE_ITYPE, `OPCODE_STORE,
		`OPCODE_BRANCH, `OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL};

	decode_stage u_decode_stage (.*);

	always #5 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic instr_t next_random();
		return $random(seed);
	endfunction

	// Top bit of one random word
	function automatic logic random_bit();
		instr_t r;
		r = next_random();
		return r[31];
	endfunction

	function automatic instr_t with_opcode(input instr_t base, input opcode_t opc);
		return {base[31:7], opc};
	endfunction

	function automatic instr_t with_funct3(input instr_t base, input funct3_t f3);
		return {base[31:15], f3, base[11:0]};
	endfunction

	// DUT outputs packed like the model's control word
	function automatic ctrl_word_t dut_ctrl();
		return {jump, branch, alu_src_a_select, alu_src_b_select, csr_write_enable,
			register_file_write, register_file_write_data_select, memory_read,
			memory_write, illegal};
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatch_count++;
			$display("mismatch %s: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("mismatch %s control: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_imm(input string name, input imm_t exp, input imm_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("mismatch %s imm: expected %h actual %h", name, exp, act);
		end
	endtask

	// rd, rs1, rs2 and CSR address together
	task automatic check_regs(input string name, input reg_addr_t exp_rd,
		input reg_addr_t exp_rs1, input reg_addr_t exp_rs2, input csr_addr_t exp_csr);
		if ({rd_addr, rs1_addr, rs2_addr, csr_addr} !== {exp_rd, exp_rs1, exp_rs2, exp_csr}) begin
			mismatch_count++;
			$display("mismatch %s regs: expected %h %h %h %h actual %h %h %h %h", name,
				exp_rd, exp_rs1, exp_rs2, exp_csr, rd_addr, rs1_addr, rs2_addr, csr_addr);
		end
	endtask

	// One strobe with a fresh random write_done
	task automatic send_instr(input instr_t i, input string name);
		@(posedge clk);
		#1;
		instr_valid = 1'b1;
		instr       = i;
		write_done  = random_bit();
		instr_q.push_back(i);
		name_q.push_back(name);
		cycle_q.push_back(cycle);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		instr       = next_random();
		write_done  = random_bit();
	endtask

	// Sample mid-cycle where outputs have settled
	always @(negedge clk) begin
		check_bit("pc_stall", !write_done, pc_stall);
		if (arst_n && out_valid) begin
			if (instr_q.size() == 0) begin
				protocol_count++;
				$display("out_valid was high with no instruction outstanding");
			end else begin
				sent_instr = instr_q.pop_front();
				sent_name  = name_q.pop_front();
				sent_cycle = cycle_q.pop_front();
				exp_word   = decode_ref(sent_instr);
				if (cycle != sent_cycle + 1) begin
					mismatch_count++;
					$display("mismatch %s latency: expected %0d actual %0d", sent_name,
						sent_cycle + 1, cycle);
				end
				check_ctrl(sent_name, exp_word.ctrl, dut_ctrl());
				check_imm(sent_name, exp_word.imm, imm);
				check_regs(sent_name, exp_word.rd, exp_word.rs1, exp_word.rs2,
					exp_word.csr_addr);
			end
		end
	end

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		write_done  = 1'b0;
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;

		// Idle outputs before any strobe
		@(negedge clk);
		check_bit("reset out_valid", 1'b0, out_valid);
		check_ctrl("reset", idle_ctrl(), dut_ctrl());

		// One of each opcode
		for (k = 0; k < 11; k++)
			send_instr(with_opcode(next_random(), listed_ops[k]), "directed opcode");
		// Every CSR funct3 including the zero no-op
		for (k = 0; k < 8; k++)
			send_instr(with_funct3(with_opcode(next_random(), `OPCODE_ENVIRONMENT),
				funct3_t'(k)), "directed csr");
		send_instr(with_funct3(with_opcode(next_random(), `OPCODE_ITYPE), `ITYPE_SRXI),
			"directed shift right");

		// Immediates with alternating sign bit
		for (n = 0; n < 16; n++) begin
			for (k = 0; k < 8; k++) begin
				rnd = next_random();
				send_instr(with_opcode({n[0], rnd[30:0]}, imm_ops[k]), "immediate format");
			end
			send_instr(with_funct3(with_opcode(next_random(), `OPCODE_ENVIRONMENT),
				funct3_t'(5 + n % 3)), "csr uimm");
		end

		// Unlisted opcodes
		for (n = 0; n < 20; n++) begin
			rnd = next_random();
			op  = rnd[6:0];
			while (is_listed_opcode(op))
				op = op + 7'd1;
			send_instr(with_opcode(rnd, op), "illegal opcode");
		end

		// Stream with random gaps
		for (n = 0; n < 200; n++) begin
			rnd = next_random();
			if (rnd[1:0] == 2'b00)
				idle_cycle();
			if (rnd[31])
				send_instr(with_opcode(next_random(), listed_ops[rnd[15:8] % 11]), "stream");
			else
				send_instr(next_random(), "stream");
		end
		idle_cycle();

		// Bounded drain
		wait_cycles = 0;
		while (instr_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (instr_q.size() != 0) begin
			timeout_count++;
			$display("timed out with %0d instructions never leaving the decode stage",
				instr_q.size());
		end
		@(negedge clk);

		$display("errors: %0d mismatch, %0d protocol, %0d timeout",
			mismatch_count, protocol_count, timeout_count);
		if (mismatch_count + protocol_count + timeout_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
